// File: run.sh
#!/usr/bin/env bash
# compile and run the port block testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f vlog.f \
	--Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1

// File: src/bus_ifs.sv
/* interfaces between the pipeline stages; every access is a one-cycle
   wr or rd strobe with its payload valid in the same cycle */

// stage 1 to stage 2, raw sampled cpu cycle
interface io_cycle_if;
	import zx_ports_pkg::*;

	logic       wr;
	logic       rd;
	logic [15:0] addr;
	cpu_byte_u  data;

	modport src (output wr, output rd, output addr, output data);
	modport dst (input wr, input rd, input addr, input data);
endinterface

// stage 2 to stage 3, decoded port access
interface port_access_if;
	import zx_ports_pkg::*;

	logic       wr;
	logic       rd;
	port_sel_e  sel;
	logic [7:0] index; // address high byte
	cpu_byte_u  data;

	modport src (
		output wr,
		output rd,
		output sel,
		output index,
		output data
	);
	modport dst (
		input wr,
		input rd,
		input sel,
		input index,
		input data
	);
endinterface

// File: src/io_bus_sync.sv
/* stage 1: samples the asynchronous z80 I/O cycle on zclk and turns each
   cycle into a single read or write strobe with address and data */

module io_bus_sync (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	io_cycle_if.src     bus
);

	logic iowr_s, iord_s; // sampled bus conditions
	logic iowr_d, iord_d; // one cycle older
	logic start;

	assign start = (iowr_s & ~iowr_d) | (iord_s & ~iord_d);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_s <= 1'b0;
			iord_s <= 1'b0;
			iowr_d <= 1'b0;
			iord_d <= 1'b0;
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
		end
		else
		begin
			iowr_s <= ~(iorq_n | wr_n);
			iord_s <= ~(iorq_n | rd_n);
			iowr_d <= iowr_s;
			iord_d <= iord_s;
			bus.wr <= iowr_s & ~iowr_d; // first cycle only
			bus.rd <= iord_s & ~iord_d;
		end
	end

	// bus still stable here, iorq is held for several cycles
	always_ff @(posedge zclk)
		if (start)
		begin
			bus.addr     <= a;
			bus.data.raw <= din;
		end

endmodule

// File: src/mem_paging.sv
/* stage 3b: memory paging through #7FFD, #EFF7 and #nnAF, the #xxBF shadow
   and rom-write control, and the read-back byte of #xxBF and #xxBE */

module mem_paging (
	input  logic       zclk,
	input  logic       rst_n,
	port_access_if.dst acc,
	input  logic       dos,
	output logic [7:0] vpage,
	output logic [7:0] rampage0,
	output logic [7:0] rampage1,
	output logic [7:0] rampage2,
	output logic [7:0] rampage3,
	output logic [7:0] peff7,
	output logic       rom_sel,
	output logic       romrw_en,
	output logic       shadow,
	output logic [7:0] dout,
	output logic       dout_valid
);
	import zx_ports_pkg::*;

	cpu_byte_u  d;
	ext_reg_e   idx;
	logic [7:0] p7ffd_reg;
	logic [7:0] peff7_reg;
	logic       lock_7ffd;
	logic       shadow_en;  // #BF bit 0
	logic       block1m;    // EFF7 bit 2, 128k-only paging
	logic [7:0] rd_byte;

	assign d       = acc.data;
	assign idx     = ext_reg_e'(acc.index);
	assign block1m = peff7_reg[2];
	assign shadow  = dos | shadow_en;
	assign peff7   = block1m ? {peff7_reg[7], 1'b0, peff7_reg[5:4], 3'b000, peff7_reg[0]}
	                         : peff7_reg;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd_reg <= 8'h00;
			peff7_reg <= 8'h00;
			lock_7ffd <= 1'b0;
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			rom_sel   <= 1'b0;
			vpage     <= VPAGE_RST;
			rampage0  <= RAMPAGE0_RST;
			rampage1  <= RAMPAGE1_RST;
			rampage2  <= RAMPAGE2_RST;
			rampage3  <= RAMPAGE3_RST;
		end
		else if (acc.wr)
		begin
			case (acc.sel)
				sel_p7ffd:
				begin
					if (!lock_7ffd) // locked until reset
					begin
						p7ffd_reg <= d.raw;
						rom_sel   <= d.p7ffd.rom;
						vpage     <= {6'b000001, d.p7ffd.screen, 1'b1}; // screen 5 or 7
						if (block1m)
							rampage3 <= {5'b00000, d.p7ffd.ram_lo};
						else
							rampage3 <= {2'b00, d.p7ffd.page_b5, d.p7ffd.ram_hi,
							             d.p7ffd.ram_lo};
						lock_7ffd <= block1m & d.p7ffd.page_b5;
					end
				end
				sel_ext_af:
				begin
					case (idx)
						idx_vpage:    vpage    <= d.raw;
						idx_rampage0: rampage0 <= d.raw;
						idx_rampage1: rampage1 <= d.raw;
						idx_rampage2: rampage2 <= d.raw;
						idx_rampage3: rampage3 <= d.raw;
						default:
						begin
						end
					endcase
				end
				sel_peff7: peff7_reg <= d.raw;
				sel_zxev_bf:
				begin
					shadow_en <= d.raw[0];
					romrw_en  <= d.raw[1];
				end
				default:
				begin
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// read-back
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		rd_byte = 8'hFF; // nothing else reads back
		if (acc.sel == sel_zxev_bf)
			rd_byte = {6'b000000, romrw_en, shadow_en};
		else if (acc.sel == sel_zxev_be)
		begin
			if (acc.index[3:0] == BE_SEL_7FFD)
				rd_byte = p7ffd_reg;
			else if (acc.index[3:0] == BE_SEL_EFF7)
				rd_byte = peff7_reg; // unmasked
		end
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			dout_valid <= 1'b0;
		else
			dout_valid <= acc.rd;
	end

	always_ff @(posedge zclk)
		if (acc.rd)
			dout <= rd_byte;

endmodule

// File: src/port_decode.sv
/* stage 2: maps the low address byte of each access to a port select,
   with the shadow (dos) rules of #7FFD and #EFF7 applied */

module port_decode (
	input  logic       zclk,
	input  logic       rst_n,
	io_cycle_if.dst    cyc,
	input  logic       shadow,
	port_access_if.src acc
);
	import zx_ports_pkg::*;

	port_sel_e sel_c;

	always_comb
	begin
		sel_c = sel_none;
		case (cyc.addr[7:0])
			PORT_AF: sel_c = sel_ext_af;
			PORT_FE: sel_c = sel_border_fe;
			PORT_FD:
			begin
				if (!cyc.addr[15]) // 7FFD only, BFFD/FFFD belong to the AY
					sel_c = sel_p7ffd;
			end
			PORT_F7:
			begin
				// EFF7 is hidden in shadow mode
				if (cyc.addr[8] && !cyc.addr[12] && !shadow)
					sel_c = sel_peff7;
			end
			PORT_BF: sel_c = sel_zxev_bf;
			PORT_BE: sel_c = sel_zxev_be;
			default: sel_c = sel_none;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			acc.wr <= 1'b0;
			acc.rd <= 1'b0;
		end
		else
		begin
			acc.wr <= cyc.wr;
			acc.rd <= cyc.rd;
		end
	end

	always_ff @(posedge zclk)
		if (cyc.wr || cyc.rd)
		begin
			acc.sel   <= sel_c;
			acc.index <= cyc.addr[15:8];
			acc.data  <= cyc.data;
		end

endmodule

// File: src/sys_config_regs.sv
/* stage 3a: video, interrupt and system registers written through #nnAF,
   plus the #FE border colour */

module sys_config_regs #(
	parameter logic [7:0] HINT_RESET = 8'd1
) (
	input  logic       zclk,
	input  logic       rst_n,
	port_access_if.dst acc,
	output logic [7:0] vconf,
	output logic [7:0] tsconf,
	output logic [7:0] sysconf,
	output logic [7:0] memconf,
	output logic [7:0] hint_beg,
	output logic [7:0] im2vect,
	output logic [8:0] x_offs,
	output logic [8:0] y_offs,
	output logic [8:0] vint_beg,
	output logic [3:0] border
);
	import zx_ports_pkg::*;

	ext_reg_e   idx;
	logic [7:0] d;

	assign idx = ext_reg_e'(acc.index);
	assign d   = acc.data.raw;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			vconf    <= 8'h00;
			tsconf   <= 8'h00;
			sysconf  <= 8'h00;
			memconf  <= 8'h00;
			hint_beg <= HINT_RESET; // depends on board border timing
			im2vect  <= IM2VECT_RST;
			x_offs   <= 9'd0;
			y_offs   <= 9'd0;
			vint_beg <= 9'd0;
			border   <= 4'd0;
		end
		else if (acc.wr && acc.sel == sel_ext_af)
		begin
			case (idx)
				idx_vconf:    vconf         <= d;
				idx_xoffs_lo: x_offs[7:0]   <= d;
				idx_xoffs_hi: x_offs[8]     <= d[0]; // only bit 0 counts
				idx_yoffs_lo: y_offs[7:0]   <= d;
				idx_yoffs_hi: y_offs[8]     <= d[0];
				idx_tsconf:   tsconf        <= d;
				idx_sysconf:  sysconf       <= d;
				idx_memconf:  memconf       <= d;
				idx_hsint:    hint_beg      <= d;
				idx_vsint_lo: vint_beg[7:0] <= d;
				idx_vsint_hi: vint_beg[8]   <= d[0];
				idx_im2vect:  im2vect       <= d;
				default:
				begin
					// paging indices and unknown ones
				end
			endcase
		end
		else if (acc.wr && acc.sel == sel_border_fe)
		begin
			border <= {d[7], d[2:0]}; // bit 7 is the extra tsconf colour bit
		end
	end

endmodule

// File: src/zx_ports.sv
/* top of the z80 I/O port block: sync, decode, then the two register
   stages side by side; read data comes back three cycles after the access */

module zx_ports #(
	parameter logic [7:0] HINT_RESET = 8'd1
) (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        dos,

	output logic [7:0]  vconf,
	output logic [7:0]  tsconf,
	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [7:0]  hint_beg,
	output logic [7:0]  im2vect,
	output logic [8:0]  x_offs,
	output logic [8:0]  y_offs,
	output logic [8:0]  vint_beg,
	output logic [3:0]  border,

	output logic [7:0]  vpage,
	output logic [7:0]  rampage0,
	output logic [7:0]  rampage1,
	output logic [7:0]  rampage2,
	output logic [7:0]  rampage3,
	output logic [7:0]  peff7,
	output logic        rom_sel,
	output logic        romrw_en,
	output logic        shadow,
	output logic [7:0]  dout,
	output logic        dout_valid
);

	io_cycle_if    cyc_if ();
	port_access_if acc_if ();

	io_bus_sync u_sync (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.a      (a),
		.din    (din),
		.bus    (cyc_if.src)
	);

	port_decode u_decode (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.cyc    (cyc_if.dst),
		.shadow (shadow), // fed back from paging
		.acc    (acc_if.src)
	);

	sys_config_regs #(.HINT_RESET(HINT_RESET)) u_sys (
		.zclk     (zclk),
		.rst_n    (rst_n),
		.acc      (acc_if.dst),
		.vconf    (vconf),
		.tsconf   (tsconf),
		.sysconf  (sysconf),
		.memconf  (memconf),
		.hint_beg (hint_beg),
		.im2vect  (im2vect),
		.x_offs   (x_offs),
		.y_offs   (y_offs),
		.vint_beg (vint_beg),
		.border   (border)
	);

	mem_paging u_paging (
		.zclk       (zclk),
		.rst_n      (rst_n),
		.acc        (acc_if.dst),
		.dos        (dos),
		.vpage      (vpage),
		.rampage0   (rampage0),
		.rampage1   (rampage1),
		.rampage2   (rampage2),
		.rampage3   (rampage3),
		.peff7      (peff7),
		.rom_sel    (rom_sel),
		.romrw_en   (romrw_en),
		.shadow     (shadow),
		.dout       (dout),
		.dout_valid (dout_valid)
	);

endmodule

// File: src/zx_ports_pkg.sv
/* port numbers, #nnAF register indices, reset values and the cpu data byte
   shared by every stage of the I/O port block */

package zx_ports_pkg;

	////////////////////////////////////////////////////////////////////
	// port selects and #nnAF register indices
	////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		sel_none,
		sel_ext_af,
		sel_border_fe,
		sel_p7ffd,
		sel_peff7,
		sel_zxev_bf,
		sel_zxev_be
	} port_sel_e;

	// index lives in the high address byte of #nnAF
	typedef enum logic [7:0] {
		idx_vconf    = 8'd0,
		idx_vpage    = 8'd1,
		idx_xoffs_lo = 8'd2,
		idx_xoffs_hi = 8'd3,
		idx_yoffs_lo = 8'd4,
		idx_yoffs_hi = 8'd5,
		idx_tsconf   = 8'd6,
		idx_rampage0 = 8'd16,
		idx_rampage1 = 8'd17,
		idx_rampage2 = 8'd18,
		idx_rampage3 = 8'd19,
		idx_sysconf  = 8'd32,
		idx_memconf  = 8'd33,
		idx_hsint    = 8'd34,
		idx_vsint_lo = 8'd35,
		idx_vsint_hi = 8'd36,
		idx_im2vect  = 8'd37
	} ext_reg_e;

	typedef struct packed {
		logic [1:0] ram_hi;  // pentagon 1M extra page bits
		logic       page_b5; // lock, or page bit 5 in 1M mode
		logic       rom;
		logic       screen;
		logic [2:0] ram_lo;
	} p7ffd_t;

	typedef union packed {
		logic [7:0] raw;
		p7ffd_t     p7ffd;
	} cpu_byte_u;

	////////////////////////////////////////////////////////////////////
	// port map and reset values
	////////////////////////////////////////////////////////////////////

	localparam logic [7:0] PORT_AF = 8'hAF;
	localparam logic [7:0] PORT_FE = 8'hFE;
	localparam logic [7:0] PORT_FD = 8'hFD;
	localparam logic [7:0] PORT_F7 = 8'hF7;
	localparam logic [7:0] PORT_BF = 8'hBF;
	localparam logic [7:0] PORT_BE = 8'hBE;

	localparam logic [7:0] VPAGE_RST    = 8'h05;
	localparam logic [7:0] RAMPAGE0_RST = 8'd0;
	localparam logic [7:0] RAMPAGE1_RST = 8'd5;
	localparam logic [7:0] RAMPAGE2_RST = 8'd2;
	localparam logic [7:0] RAMPAGE3_RST = 8'd0;
	localparam logic [7:0] IM2VECT_RST  = 8'hFF;

	localparam logic [3:0] BE_SEL_7FFD = 4'hA; // #xxBE read-back selects
	localparam logic [3:0] BE_SEL_EFF7 = 4'hB;

endpackage

// File: verif/port_monitor.sv
/* reference model of the I/O port block; follows every z80 access seen on the
   bus, compares the register outputs and the read-back byte, counts errors */

module port_monitor #(
	parameter logic [7:0] HINT_RESET = 8'd1
) (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        dos,
	input  logic [7:0]  vconf, tsconf, sysconf, memconf, hint_beg, im2vect,
	input  logic [8:0]  x_offs, y_offs, vint_beg,
	input  logic [3:0]  border,
	input  logic [7:0]  vpage, rampage0, rampage1, rampage2, rampage3, peff7,
	input  logic        rom_sel, romrw_en, shadow,
	input  logic [7:0]  dout,
	input  logic        dout_valid,
	output int          err_count,
	output int          check_count,
	output int          read_count,
	output int          pulse_count
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] m_vconf, m_tsconf, m_sysconf, m_memconf, m_hint, m_im2vect;
	logic [8:0] m_xoffs, m_yoffs, m_vint;
	logic [3:0] m_border;
	logic [7:0] m_vpage, m_rampage0, m_rampage1, m_rampage2, m_rampage3;
	logic [7:0] m_p7ffd, m_peff7;
	logic       m_lock, m_shadow_en, m_romrw_en, m_rom_sel;

	logic [7:0] rd_q[$]; // expected read-back bytes in flight
	logic       prev_wr, prev_rd, prev_rst, wr_c, rd_c;
	logic [7:0] exp_dout;
	int         cmp_cnt = 0;
	int         errs = 0;
	int         checks = 0;
	int         reads = 0;
	int         pulses = 0;

	assign err_count   = errs;
	assign check_count = checks;
	assign read_count  = reads;
	assign pulse_count = pulses;

	////////////////////////////////////////////////////////////////////
	// model
	////////////////////////////////////////////////////////////////////

	task automatic reset_model();
		m_vconf     = 8'h00;
		m_tsconf    = 8'h00;
		m_sysconf   = 8'h00;
		m_memconf   = 8'h00;
		m_hint      = HINT_RESET;
		m_im2vect   = 8'hFF;
		m_xoffs     = 9'd0;
		m_yoffs     = 9'd0;
		m_vint      = 9'd0;
		m_border    = 4'd0;
		m_vpage     = 8'h05;
		m_rampage0  = 8'd0;
		m_rampage1  = 8'd5;
		m_rampage2  = 8'd2;
		m_rampage3  = 8'd0;
		m_p7ffd     = 8'h00;
		m_peff7     = 8'h00;
		m_lock      = 1'b0;
		m_shadow_en = 1'b0;
		m_romrw_en  = 1'b0;
		m_rom_sel   = 1'b0;
	endtask

	// #nnAF, index in the high byte
	task automatic write_ext(input logic [7:0] idx, input logic [7:0] d);
		case (idx)
			8'd0:  m_vconf = d;
			8'd1:  m_vpage = d;
			8'd2:  m_xoffs[7:0] = d;
			8'd3:  m_xoffs[8] = d[0];
			8'd4:  m_yoffs[7:0] = d;
			8'd5:  m_yoffs[8] = d[0];
			8'd6:  m_tsconf = d;
			8'd16: m_rampage0 = d;
			8'd17: m_rampage1 = d;
			8'd18: m_rampage2 = d;
			8'd19: m_rampage3 = d;
			8'd32: m_sysconf = d;
			8'd33: m_memconf = d;
			8'd34: m_hint = d;
			8'd35: m_vint[7:0] = d;
			8'd36: m_vint[8] = d[0];
			8'd37: m_im2vect = d;
			default: ;
		endcase
	endtask

	task automatic apply_write(input logic [15:0] adr, input logic [7:0] d);
		case (adr[7:0])
			8'hAF: write_ext(adr[15:8], d);
			8'hFE: m_border = {d[7], d[2:0]};
			8'hFD:
			begin
				if (!adr[15] && !m_lock)
				begin
					m_p7ffd   = d;
					m_rom_sel = d[4];
					m_vpage   = d[3] ? 8'd7 : 8'd5;
					if (m_peff7[2]) // 1M mode blocked
						m_rampage3 = {5'd0, d[2:0]};
					else
						m_rampage3 = {2'd0, d[5], d[7:6], d[2:0]};
					m_lock = m_peff7[2] & d[5];
				end
			end
			8'hF7:
			begin
				if (adr[8] && !adr[12] && !(dos || m_shadow_en))
					m_peff7 = d;
			end
			8'hBF:
			begin
				m_shadow_en = d[0];
				m_romrw_en  = d[1];
			end
			default: ;
		endcase
	endtask

	function automatic logic [7:0] read_byte(input logic [15:0] adr);
		if (adr[7:0] == 8'hBF)
			return {6'd0, m_romrw_en, m_shadow_en};
		if (adr[7:0] == 8'hBE && adr[11:8] == 4'hA)
			return m_p7ffd;
		if (adr[7:0] == 8'hBE && adr[11:8] == 4'hB)
			return m_peff7; // read back unmasked
		return 8'hFF;
	endfunction

	////////////////////////////////////////////////////////////////////
	// comparison
	////////////////////////////////////////////////////////////////////

	task automatic check_val(input string name, input logic [8:0] exp, input logic [8:0] act);
		checks++;
		if (act !== exp)
		begin
			errs++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_all();
		check_val("vconf", 9'(m_vconf), 9'(vconf));
		check_val("tsconf", 9'(m_tsconf), 9'(tsconf));
		check_val("sysconf", 9'(m_sysconf), 9'(sysconf));
		check_val("memconf", 9'(m_memconf), 9'(memconf));
		check_val("hint_beg", 9'(m_hint), 9'(hint_beg));
		check_val("im2vect", 9'(m_im2vect), 9'(im2vect));
		check_val("x_offs", m_xoffs, x_offs);
		check_val("y_offs", m_yoffs, y_offs);
		check_val("vint_beg", m_vint, vint_beg);
		check_val("border", 9'(m_border), 9'(border));
		check_val("vpage", 9'(m_vpage), 9'(vpage));
		check_val("rampage0", 9'(m_rampage0), 9'(rampage0));
		check_val("rampage1", 9'(m_rampage1), 9'(rampage1));
		check_val("rampage2", 9'(m_rampage2), 9'(rampage2));
		check_val("rampage3", 9'(m_rampage3), 9'(rampage3));
		check_val("peff7", 9'(m_peff7[2] ? (m_peff7 & 8'hB1) : m_peff7), 9'(peff7));
		check_val("rom_sel", 9'(m_rom_sel), 9'(rom_sel));
		check_val("romrw_en", 9'(m_romrw_en), 9'(romrw_en));
		check_val("shadow", 9'(dos | m_shadow_en), 9'(shadow));
	endtask

	always @(posedge zclk)
	begin
		if (!rst_n)
		begin
			reset_model();
			rd_q.delete();
			cmp_cnt = 0;
			prev_wr = 1'b0;
			prev_rd = 1'b0;
		end
		else
		begin
			if (!prev_rst)
				compare_all(); // reset values
			if (dout_valid)
			begin
				pulses++;
				if (rd_q.size() == 0)
				begin
					errs++;
					$display("dout_valid pulse at %0t ns with no read pending", $time);
				end
				else
				begin
					exp_dout = rd_q.pop_front();
					check_val("dout", 9'(exp_dout), 9'(dout));
				end
			end
			if (cmp_cnt != 0)
			begin
				cmp_cnt--;
				if (cmp_cnt == 0)
				begin
					if (rd_q.size() != 0)
					begin
						errs++;
						$display("read before %0t ns gave no dout_valid pulse", $time);
						rd_q.delete();
					end
					compare_all();
				end
			end
			wr_c = !iorq_n && !wr_n;
			rd_c = !iorq_n && !rd_n;
			if (wr_c && !prev_wr)
			begin
				apply_write(a, din);
				cmp_cnt = 6;
			end
			if (rd_c && !prev_rd)
			begin
				rd_q.push_back(read_byte(a));
				reads++;
				cmp_cnt = 6;
			end
			prev_wr = wr_c;
			prev_rd = rd_c;
		end
		prev_rst = rst_n;
	end

endmodule

// File: verif/tb_clock.sv
/* free-running zclk for the testbench, 8 ns period */

module tb_clock #(
	parameter int HALF_NS = 4
) (
	output logic zclk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial zclk = 1'b0;

	always #(HALF_NS) zclk = ~zclk;

endmodule

// File: verif/tb_top.sv
/* testbench top: reset, random z80 I/O cycles against the port block,
   watchdog and the closing summary */

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          N_ACCESS    = 1500;
	localparam int          WATCHDOG_NS = N_ACCESS * 8 * 8 + 2000;
	localparam logic [7:0]  HINT_RST    = 8'd3;
	localparam logic [31:0] SEED        = 32'h7fc44a06;
	localparam logic [7:0]  AF_INDEX [17] = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6,
		8'd16, 8'd17, 8'd18, 8'd19, 8'd32, 8'd33, 8'd34, 8'd35, 8'd36, 8'd37};

	logic        zclk, rst_n, iorq_n, rd_n, wr_n, dos;
	logic [15:0] a;
	logic [7:0]  din;
	logic [7:0]  vconf, tsconf, sysconf, memconf, hint_beg, im2vect;
	logic [8:0]  x_offs, y_offs, vint_beg;
	logic [3:0]  border;
	logic [7:0]  vpage, rampage0, rampage1, rampage2, rampage3, peff7, dout;
	logic        rom_sel, romrw_en, shadow, dout_valid;
	int          err_count, check_count, read_count, pulse_count;

	tb_clock u_clk (.zclk(zclk));

	zx_ports #(.HINT_RESET(HINT_RST)) i_dut (.*);

	port_monitor #(.HINT_RESET(HINT_RST)) u_mon (.*);

	////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////

	// kept ports more often, mostly with meaningful high bytes
	function automatic logic [15:0] pick_addr();
		int unsigned kind;
		logic [7:0]  hi;
		kind = $urandom_range(0, 15);
		hi   = 8'($urandom);
		if (kind < 4)
		begin
			if ($urandom_range(0, 4) != 0)
				hi = AF_INDEX[$urandom_range(0, 16)];
			return {hi, 8'hAF};
		end
		if (kind == 4)
			return {hi, 8'hFE};
		if (kind < 7)
			return {($urandom_range(0, 3) == 0) ? hi : {1'b0, hi[6:0]}, 8'hFD};
		if (kind < 9)
			return {($urandom_range(0, 3) == 0) ? hi : 8'hEF, 8'hF7};
		if (kind == 9)
			return {hi, 8'hBF};
		if (kind < 12)
		begin
			if ($urandom_range(0, 3) == 0)
				return {hi, 8'hBE}; // other read-back selects give FF
			return {hi[7:4], ($urandom_range(0, 1) != 0) ? 4'hA : 4'hB, 8'hBE};
		end
		return 16'($urandom);
	endfunction

	// one z80 cycle: 3 cycles active, 5 idle
	task automatic do_access(input logic is_rd, input logic [15:0] adr, input logic [7:0] d);
		@(posedge zclk);
		a      <= adr;
		din    <= d;
		iorq_n <= 1'b0;
		if (is_rd)
			rd_n <= 1'b0;
		else
			wr_n <= 1'b0;
		repeat (3) @(posedge zclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		repeat (2) @(posedge zclk);
		if ($urandom_range(0, 15) == 0)
			dos <= ~dos; // only while idle
		repeat (2) @(posedge zclk);
	endtask

	task automatic pulse_reset();
		@(posedge zclk);
		rst_n <= 1'b0;
		repeat (3) @(posedge zclk);
		rst_n <= 1'b1;
	endtask

	initial
	begin
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		a      = 16'h0000;
		din    = 8'h00;
		dos    = 1'b0;
		rst_n  = 1'b0;
		void'($urandom(SEED));
		repeat (3) @(posedge zclk);
		rst_n <= 1'b1;
		do_access(1'b1, 16'h00BF, 8'h00); // #BF read-back straight after reset
		for (int n = 0; n < N_ACCESS; n++)
		begin
			if (n != 0 && n % 500 == 0)
				pulse_reset(); // clears the 7FFD lock
			do_access($urandom_range(0, 9) < 3, pick_addr(), 8'($urandom));
		end
		repeat (10) @(posedge zclk);
		$display("checks: %0d, errors: %0d, reads: %0d, dout_valid pulses: %0d",
		         check_count, err_count, read_count, pulse_count);
		if (err_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: verif/zx_ports_checker.sv
/* strobe timing assertions, bound into the port block top; a read edge sampled
   at E shows dout_valid in the cycle that begins at E+3 */

module zx_ports_checker (
	input logic zclk,
	input logic rst_n,
	input logic iorq_n,
	input logic rd_n,
	input logic cyc_wr,
	input logic cyc_rd,
	input logic acc_wr,
	input logic acc_rd,
	input logic dout_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic rd_cond;

	assign rd_cond = !iorq_n && !rd_n;

	a_rd_latency: assert property (@(posedge zclk) disable iff (!rst_n)
		$rose(rd_cond) |-> ##1 !dout_valid ##1 !dout_valid ##1 !dout_valid ##1 dout_valid)
		else $error("dout_valid did not come three cycles after the read edge");

	a_one_pulse: assert property (@(posedge zclk) disable iff (!rst_n)
		dout_valid |=> !dout_valid)
		else $error("dout_valid high for two cycles");

	// wr and rd exclusive at both stage boundaries
	a_strobe_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(cyc_wr && cyc_rd) && !(acc_wr && acc_rd))
		else $error("wr and rd strobes high together");

	a_reset_valid: assert property (@(posedge zclk) $rose(rst_n) |-> !dout_valid)
		else $error("dout_valid set right after reset");

endmodule

bind zx_ports zx_ports_checker u_chk (
	.zclk       (zclk),
	.rst_n      (rst_n),
	.iorq_n     (iorq_n),
	.rd_n       (rd_n),
	.cyc_wr     (cyc_if.wr),
	.cyc_rd     (cyc_if.rd),
	.acc_wr     (acc_if.wr),
	.acc_rd     (acc_if.rd),
	.dout_valid (dout_valid)
);

// File: vlog.f
src/zx_ports_pkg.sv
src/bus_ifs.sv
src/io_bus_sync.sv
src/port_decode.sv
src/sys_config_regs.sv
src/mem_paging.sv
src/zx_ports.sv
verif/tb_clock.sv
verif/port_monitor.sv
verif/zx_ports_checker.sv
verif/tb_top.sv
